/* verilog/xt_bus_pkg.sv */
// XT bus glue shared definitions
// Bus widths, I/O block numbers, port and memory windows, PPI port B bit map
package xt_bus_pkg;

    localparam int ADDR_WIDTH     = 20;
    localparam int DATA_WIDTH     = 8;
    localparam int IO_BLOCK_WIDTH = 3;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [IO_BLOCK_WIDTH-1:0] io_block_t;

    // 32-port blocks below port 0x100, taken from address bits 7:5
    localparam io_block_t IO_BLOCK_DMA      = 3'd0;
    localparam io_block_t IO_BLOCK_PIC      = 3'd1;
    localparam io_block_t IO_BLOCK_PIT      = 3'd2;
    localparam io_block_t IO_BLOCK_PPI      = 3'd3;
    localparam io_block_t IO_BLOCK_DMA_PAGE = 3'd4;

    // Port windows as base plus count of ignored low address bits
    localparam logic [15:0] OPL_PORT_BASE  = 16'h0388;
    localparam int          OPL_PORT_BITS  = 1;
    localparam logic [15:0] UART_PORT_BASE = 16'h03F8;
    localparam int          UART_PORT_BITS = 3;

    // Memory windows on the top address bits
    localparam logic [5:0] CGA_WINDOW  = 6'b101110;
    localparam logic [5:0] MDA_WINDOW  = 6'b101100;
    localparam logic [3:0] ROM_NIBBLE  = 4'hF;
    localparam logic [3:0] VRAM_NIBBLE = 4'hB;
    localparam addr_t      RAM_LIMIT   = 20'hB0000;

    // OPL read while the card is hidden
    localparam data_t HIDDEN_READ = 8'hFF;

    // PPI port B bits
    localparam int PB_TIMER_GATE    = 0;
    localparam int PB_SPEAKER_DATA  = 1;
    localparam int PB_KBD_RESET_N   = 6;
    localparam int PB_CLEAR_KEYCODE = 7;

endpackage

/* verilog/cpu_bus_if.sv */
// CPU bus request signals
// Shared by the address decoder, the read-back mux and the UART strobes
`timescale 1ns/100ps

interface cpu_bus_if
    import xt_bus_pkg::*;
();

    addr_t  address;
    logic   aen_n;
    logic   io_read_n;
    logic   io_write_n;
    logic   memory_read_n;

    modport decoder (input address, input aen_n);

    // Read-back only cares about the read strobes
    modport mux (input io_read_n, input memory_read_n);

    modport uart (input io_read_n, input io_write_n);

endinterface

/* verilog/bus_select_if.sv */
// Decoded chip selects, active high
// Driven by the address decoder, read by the read-back mux and the top level
`timescale 1ns/100ps

interface bus_select_if ();

    logic   dma;
    logic   pic;
    logic   pit;
    logic   ppi;
    logic   dma_page;
    logic   opl;
    logic   uart;
    logic   cga;
    logic   mda;
    logic   rom;
    logic   ram;

    modport source (
        output dma, pic, pit, ppi, dma_page, opl, uart, cga, mda, rom, ram
    );

    modport sink (
        input dma, pic, pit, ppi, dma_page, opl, uart, cga, mda, rom, ram
    );

endinterface

/* verilog/xt_address_decoder.sv */
// XT address decoder
// I/O block selects below port 0x100, OPL and UART port windows,
// VRAM, BIOS ROM and RAM memory windows
`timescale 1ns/100ps

module xt_address_decoder
    import xt_bus_pkg::*;
(
    cpu_bus_if.decoder      bus_i,
    input  logic            cga_enable_i,
    input  logic            mda_enable_i,
    bus_select_if.source    sel_o
);

    io_block_t      io_block;
    logic           io_space;
    logic   [3:0]   top_nibble;

    // Ports 0x000-0x0FF only, aliased every 0x400
    assign io_block = bus_i.address[7:5];
    assign io_space = ~bus_i.aen_n & (bus_i.address[9:8] == 2'b00);

    assign sel_o.dma      = io_space & (io_block == IO_BLOCK_DMA);
    assign sel_o.pic      = io_space & (io_block == IO_BLOCK_PIC);
    assign sel_o.pit      = io_space & (io_block == IO_BLOCK_PIT);
    assign sel_o.ppi      = io_space & (io_block == IO_BLOCK_PPI);
    assign sel_o.dma_page = io_space & (io_block == IO_BLOCK_DMA_PAGE);

    // Two blocks sharing a number would select two chips at once
    always_comb begin
        assert ($onehot0({sel_o.dma, sel_o.pic, sel_o.pit, sel_o.ppi, sel_o.dma_page}))
            else $error("more than one I/O block selected");
    end

    // Named port windows, full 16-bit port compare
    assign sel_o.opl  = bus_i.address[15:OPL_PORT_BITS] == OPL_PORT_BASE[15:OPL_PORT_BITS];
    assign sel_o.uart = bus_i.address[15:UART_PORT_BITS] == UART_PORT_BASE[15:UART_PORT_BITS];

    // Text buffers, each behind its own card enable
    assign sel_o.cga = cga_enable_i & (bus_i.address[19:14] == CGA_WINDOW);
    assign sel_o.mda = mda_enable_i & (bus_i.address[19:14] == MDA_WINDOW);

    assign top_nibble = bus_i.address[19:16];
    assign sel_o.rom  = top_nibble == ROM_NIBBLE;

    // Everything outside the VRAM and BIOS segments is RAM
    assign sel_o.ram = (bus_i.address < RAM_LIMIT) ||
                       ((top_nibble != ROM_NIBBLE) && (top_nibble != VRAM_NIBBLE));

endmodule

/* verilog/read_data_mux.sv */
// Read-back multiplexer
// Picks the byte the chipset drives to the CPU by fixed priority
`timescale 1ns/100ps

module read_data_mux
    import xt_bus_pkg::*;
(
    cpu_bus_if.mux          bus_i,
    bus_select_if.sink      sel_i,
    input  logic            interrupt_acknowledge_n_i,
    input  logic            adlib_hide_i,
    input  data_t           pic_data_i,
    input  data_t           pit_data_i,
    input  data_t           ppi_data_i,
    input  data_t           cga_vram_data_i,
    input  data_t           mda_vram_data_i,
    input  data_t           bios_data_i,
    input  data_t           ram_data_i,
    input  data_t           opl_data_i,
    input  data_t           uart_data_i,
    output data_t           data_bus_out_o,
    output logic            data_bus_out_from_chipset_o
);

    logic   io_read;
    logic   memory_read;
    logic   io_hit;
    logic   memory_hit;
    data_t  opl_read_data;

    assign io_read       = ~bus_i.io_read_n;
    assign memory_read   = ~bus_i.memory_read_n;
    assign opl_read_data = adlib_hide_i ? HIDDEN_READ : opl_data_i;

    // Chipset drives on INTA or on a read of any source it owns
    assign io_hit     = io_read &
                        (sel_i.pic | sel_i.pit | sel_i.ppi | sel_i.opl | sel_i.uart);
    assign memory_hit = memory_read & (sel_i.cga | sel_i.mda | sel_i.rom | sel_i.ram);
    assign data_bus_out_from_chipset_o = ~interrupt_acknowledge_n_i | io_hit | memory_hit;

    always_comb begin
        data_bus_out_o = '0;
        // INTA cycle returns the vector from the PIC
        if (~interrupt_acknowledge_n_i) begin
            data_bus_out_o = pic_data_i;
        end else if (sel_i.pic & io_read) begin
            data_bus_out_o = pic_data_i;
        end else if (sel_i.pit & io_read) begin
            data_bus_out_o = pit_data_i;
        end else if (sel_i.ppi & io_read) begin
            data_bus_out_o = ppi_data_i;
        end else if (sel_i.cga & memory_read) begin
            data_bus_out_o = cga_vram_data_i;
        end else if (sel_i.mda & memory_read) begin
            data_bus_out_o = mda_vram_data_i;
        end else if (sel_i.rom & memory_read) begin
            data_bus_out_o = bios_data_i;
        end else if (sel_i.ram & memory_read) begin
            data_bus_out_o = ram_data_i;
        end else if (sel_i.opl & io_read) begin
            data_bus_out_o = opl_read_data;
        end else if (sel_i.uart & io_read) begin
            data_bus_out_o = uart_data_i;
        end
    end

    // Idle bus must read back as zero
    always_comb begin
        assert (data_bus_out_from_chipset_o || (data_bus_out_o == '0))
            else $error("nonzero read-back byte while chipset is not driving");
    end

endmodule

/* verilog/peripheral_sync.sv */
// Peripheral clock domain glue
// Timer clock, keyboard IRQ and keycode into the bus domain, port B keyboard
// controls out to the peripheral domain, keyboard reset request, speaker gate
`timescale 1ns/100ps

module peripheral_sync
    import xt_bus_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic    clock,
    input  logic    peripheral_clock,
    input  logic    reset,
    input  logic    kbd_irq_i,
    input  data_t   keycode_i,
    input  data_t   port_b_i,
    input  logic    port_b_io_i,
    input  logic    pit_out2_i,
    output logic    timer_clock_o,
    output logic    keyboard_interrupt_o,
    output data_t   port_a_keycode_o,
    output logic    clear_keycode_o,
    output logic    ps2_reset_n_o,
    output logic    kbd_reset_request_o,
    output logic    timer2_gate_o,
    output logic    speaker_o
);

    logic                       timer_toggle;
    logic   [SYNC_STAGES-1:0]   timer_sync;
    logic   [SYNC_STAGES-1:0]   irq_sync;
    data_t  [SYNC_STAGES-1:0]   keycode_sync;
    logic   [SYNC_STAGES-1:0]   clear_sync;
    logic   [SYNC_STAGES-1:0]   reset_n_sync;
    logic                       prev_reset_n;

    // Peripheral domain: timer divider, port B controls, reset edge
    always_ff @(posedge peripheral_clock) begin
        if (reset) begin
            timer_toggle        <= 1'b0;
            clear_sync          <= '0;
            reset_n_sync        <= '0;
            prev_reset_n        <= 1'b0;
            kbd_reset_request_o <= 1'b0;
        end else begin
            timer_toggle        <= ~timer_toggle;
            clear_sync          <= {clear_sync[SYNC_STAGES-2:0], port_b_i[PB_CLEAR_KEYCODE]};
            reset_n_sync        <= {reset_n_sync[SYNC_STAGES-2:0], port_b_i[PB_KBD_RESET_N]};
            prev_reset_n        <= reset_n_sync[SYNC_STAGES-1];
            // Single pulse once the keyboard leaves reset
            kbd_reset_request_o <= reset_n_sync[SYNC_STAGES-1] & ~prev_reset_n;
        end
    end

    // Bus domain: timer clock, keyboard IRQ and keycode
    always_ff @(posedge clock) begin
        if (reset) begin
            timer_sync   <= '0;
            irq_sync     <= '0;
            keycode_sync <= '0;
        end else begin
            timer_sync   <= {timer_sync[SYNC_STAGES-2:0], timer_toggle};
            irq_sync     <= {irq_sync[SYNC_STAGES-2:0], kbd_irq_i};
            keycode_sync <= {keycode_sync[SYNC_STAGES-2:0], keycode_i};
        end
    end

    assign timer_clock_o        = timer_sync[SYNC_STAGES-1];
    assign keyboard_interrupt_o = irq_sync[SYNC_STAGES-1];
    assign port_a_keycode_o     = keycode_sync[SYNC_STAGES-1];
    assign clear_keycode_o      = clear_sync[SYNC_STAGES-1];
    assign ps2_reset_n_o        = reset_n_sync[SYNC_STAGES-1];

    // Port B drives the gates only when configured as output
    assign timer2_gate_o = port_b_i[PB_TIMER_GATE] & ~port_b_io_i;
    assign speaker_o     = pit_out2_i & port_b_i[PB_SPEAKER_DATA] & ~port_b_io_i;

    a_reset_request_pulse: assert property (
        @(posedge peripheral_clock) disable iff (reset)
        !(kbd_reset_request_o && $past(kbd_reset_request_o))
    ) else $error("keyboard reset request held for two cycles");

endmodule

/* verilog/uart_bus_strobe.sv */
// UART bus strobes
// Edge pulses from the I/O strobes, write byte latch and read byte capture
`timescale 1ns/100ps

module uart_bus_strobe
    import xt_bus_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    cpu_bus_if.uart bus_i,
    input  data_t   data_i,
    input  data_t   uart_readdata_i,
    output logic    uart_read_o,
    output logic    uart_write_o,
    output data_t   uart_writedata_o,
    output data_t   uart_readdata_o
);

    logic   read_n_q;
    logic   write_n_q;

    // Strobes idle high, so reset to the idle level
    always_ff @(posedge clock) begin
        if (reset) begin
            read_n_q     <= 1'b1;
            write_n_q    <= 1'b1;
            uart_read_o  <= 1'b0;
            uart_write_o <= 1'b0;
        end else begin
            read_n_q     <= bus_i.io_read_n;
            write_n_q    <= bus_i.io_write_n;
            uart_read_o  <= ~bus_i.io_read_n & read_n_q;
            uart_write_o <= bus_i.io_write_n & ~write_n_q;
        end
    end

    always_ff @(posedge clock) begin
        if (~bus_i.io_write_n) begin
            uart_writedata_o <= data_i;
        end
        // UART answers during the read pulse
        if (uart_read_o) begin
            uart_readdata_o <= uart_readdata_i;
        end
    end

endmodule

/* verilog/xt_bus_glue.sv */
// XT bus glue top level
// Address decode, read-back mux, peripheral clock crossings and UART strobes
// on plain ports for the external peripheral chips
`timescale 1ns/100ps

module xt_bus_glue #(
    parameter int SYNC_STAGES = 2
) (
    input  logic            clock,
    input  logic            peripheral_clock,
    input  logic            reset,
    // CPU bus
    input  logic    [19:0]  address_i,
    input  logic            address_enable_n_i,
    input  logic            io_read_n_i,
    input  logic            io_write_n_i,
    input  logic            memory_read_n_i,
    input  logic    [7:0]   internal_data_bus_i,
    input  logic            interrupt_acknowledge_n_i,
    input  logic            cga_enable_i,
    input  logic            mda_enable_i,
    input  logic            adlib_hide_i,
    // Read data from the external chips and memories
    input  logic    [7:0]   pic_data_i,
    input  logic    [7:0]   pit_data_i,
    input  logic    [7:0]   ppi_data_i,
    input  logic    [7:0]   cga_vram_data_i,
    input  logic    [7:0]   mda_vram_data_i,
    input  logic    [7:0]   bios_data_i,
    input  logic    [7:0]   ram_data_i,
    input  logic    [7:0]   opl_data_i,
    input  logic    [7:0]   uart_readdata_i,
    // Keyboard, PPI and timer
    input  logic            kbd_irq_i,
    input  logic    [7:0]   keycode_i,
    input  logic    [7:0]   port_b_i,
    input  logic            port_b_io_i,
    input  logic            pit_out2_i,
    // Chip selects
    output logic            dma_cs_n_o,
    output logic            pic_cs_n_o,
    output logic            pit_cs_n_o,
    output logic            ppi_cs_n_o,
    output logic            dma_page_cs_n_o,
    output logic            opl_cs_n_o,
    output logic            uart_cs_o,
    output logic            cga_cs_n_o,
    output logic            mda_cs_n_o,
    output logic            rom_cs_n_o,
    output logic            ram_cs_n_o,
    output logic    [7:0]   data_bus_out_o,
    output logic            data_bus_out_from_chipset_o,
    // Peripheral domain outputs
    output logic            timer_clock_o,
    output logic            keyboard_interrupt_o,
    output logic    [7:0]   port_a_keycode_o,
    output logic            clear_keycode_o,
    output logic            ps2_reset_n_o,
    output logic            kbd_reset_request_o,
    output logic            timer2_gate_o,
    output logic            speaker_o,
    // UART side
    output logic            uart_read_o,
    output logic            uart_write_o,
    output logic    [7:0]   uart_writedata_o,
    output logic    [7:0]   uart_readdata_o
);

    cpu_bus_if      bus ();
    bus_select_if   sel ();

    assign bus.address       = address_i;
    assign bus.aen_n         = address_enable_n_i;
    assign bus.io_read_n     = io_read_n_i;
    assign bus.io_write_n    = io_write_n_i;
    assign bus.memory_read_n = memory_read_n_i;

    xt_address_decoder u_decoder (
        .bus_i          (bus),
        .cga_enable_i   (cga_enable_i),
        .mda_enable_i   (mda_enable_i),
        .sel_o          (sel)
    );

    // External chips take active-low selects, the UART core active high
    assign dma_cs_n_o      = ~sel.dma;
    assign pic_cs_n_o      = ~sel.pic;
    assign pit_cs_n_o      = ~sel.pit;
    assign ppi_cs_n_o      = ~sel.ppi;
    assign dma_page_cs_n_o = ~sel.dma_page;
    assign opl_cs_n_o      = ~sel.opl;
    assign uart_cs_o       = sel.uart;
    assign cga_cs_n_o      = ~sel.cga;
    assign mda_cs_n_o      = ~sel.mda;
    assign rom_cs_n_o      = ~sel.rom;
    assign ram_cs_n_o      = ~sel.ram;

    read_data_mux u_read_mux (
        .bus_i                          (bus),
        .sel_i                          (sel),
        .interrupt_acknowledge_n_i      (interrupt_acknowledge_n_i),
        .adlib_hide_i                   (adlib_hide_i),
        .pic_data_i                     (pic_data_i),
        .pit_data_i                     (pit_data_i),
        .ppi_data_i                     (ppi_data_i),
        .cga_vram_data_i                (cga_vram_data_i),
        .mda_vram_data_i                (mda_vram_data_i),
        .bios_data_i                    (bios_data_i),
        .ram_data_i                     (ram_data_i),
        .opl_data_i                     (opl_data_i),
        // Captured UART byte, not the live core output
        .uart_data_i                    (uart_readdata_o),
        .data_bus_out_o                 (data_bus_out_o),
        .data_bus_out_from_chipset_o    (data_bus_out_from_chipset_o)
    );

    peripheral_sync #(
        .SYNC_STAGES    (SYNC_STAGES)
    ) u_peripheral_sync (
        .clock                  (clock),
        .peripheral_clock       (peripheral_clock),
        .reset                  (reset),
        .kbd_irq_i              (kbd_irq_i),
        .keycode_i              (keycode_i),
        .port_b_i               (port_b_i),
        .port_b_io_i            (port_b_io_i),
        .pit_out2_i             (pit_out2_i),
        .timer_clock_o          (timer_clock_o),
        .keyboard_interrupt_o   (keyboard_interrupt_o),
        .port_a_keycode_o       (port_a_keycode_o),
        .clear_keycode_o        (clear_keycode_o),
        .ps2_reset_n_o          (ps2_reset_n_o),
        .kbd_reset_request_o    (kbd_reset_request_o),
        .timer2_gate_o          (timer2_gate_o),
        .speaker_o              (speaker_o)
    );

    uart_bus_strobe u_uart_strobe (
        .clock              (clock),
        .reset              (reset),
        .bus_i              (bus),
        .data_i             (internal_data_bus_i),
        .uart_readdata_i    (uart_readdata_i),
        .uart_read_o        (uart_read_o),
        .uart_write_o       (uart_write_o),
        .uart_writedata_o   (uart_writedata_o),
        .uart_readdata_o    (uart_readdata_o)
    );

endmodule

/* bench/xt_bus_glue_tb.sv */
// Testbench for the XT bus glue
// Replays decode and read-back vectors from a data file, then checks the UART
// strobes, keyboard crossings, keyboard reset request and speaker gating
`timescale 1ns/100ps

module xt_bus_glue_tb
    import xt_bus_pkg::*;
;

    localparam int          MAX_VECTORS      = 64;
    localparam int          WORDS_PER_VECTOR = 6;
    localparam int          MAX_WORDS        = MAX_VECTORS * WORDS_PER_VECTOR;
    localparam logic [23:0] EMPTY_WORD       = 24'hFFFFFF;

    logic           clock;
    logic           peripheral_clock;
    logic           reset;
    logic   [19:0]  address_i;
    logic           address_enable_n_i;
    logic           io_read_n_i;
    logic           io_write_n_i;
    logic           memory_read_n_i;
    logic   [7:0]   internal_data_bus_i;
    logic           interrupt_acknowledge_n_i;
    logic           cga_enable_i;
    logic           mda_enable_i;
    logic           adlib_hide_i;
    logic   [7:0]   pic_data_i;
    logic   [7:0]   pit_data_i;
    logic   [7:0]   ppi_data_i;
    logic   [7:0]   cga_vram_data_i;
    logic   [7:0]   mda_vram_data_i;
    logic   [7:0]   bios_data_i;
    logic   [7:0]   ram_data_i;
    logic   [7:0]   opl_data_i;
    logic   [7:0]   uart_readdata_i;
    logic           kbd_irq_i;
    logic   [7:0]   keycode_i;
    logic   [7:0]   port_b_i;
    logic           port_b_io_i;
    logic           pit_out2_i;
    logic           dma_cs_n_o;
    logic           pic_cs_n_o;
    logic           pit_cs_n_o;
    logic           ppi_cs_n_o;
    logic           dma_page_cs_n_o;
    logic           opl_cs_n_o;
    logic           uart_cs_o;
    logic           cga_cs_n_o;
    logic           mda_cs_n_o;
    logic           rom_cs_n_o;
    logic           ram_cs_n_o;
    logic   [7:0]   data_bus_out_o;
    logic           data_bus_out_from_chipset_o;
    logic           timer_clock_o;
    logic           keyboard_interrupt_o;
    logic   [7:0]   port_a_keycode_o;
    logic           clear_keycode_o;
    logic           ps2_reset_n_o;
    logic           kbd_reset_request_o;
    logic           timer2_gate_o;
    logic           speaker_o;
    logic           uart_read_o;
    logic           uart_write_o;
    logic   [7:0]   uart_writedata_o;
    logic   [7:0]   uart_readdata_o;

    logic   [23:0]  vector_mem [0:MAX_WORDS-1];
    int             vector_count     = 0;
    logic           vectors_loaded   = 1'b0;
    int             read_pulses      = 0;
    int             write_pulses     = 0;
    int             kbd_reset_pulses = 0;
    logic   [10:0]  sel_actual;

    xt_bus_glue #(
        .SYNC_STAGES    (2)
    ) uut (.*);

    // Same bit order as the select column of the data file
    assign sel_actual = {~dma_cs_n_o, ~pic_cs_n_o, ~pit_cs_n_o, ~ppi_cs_n_o,
                         ~dma_page_cs_n_o, ~opl_cs_n_o, uart_cs_o, ~cga_cs_n_o,
                         ~mda_cs_n_o, ~rom_cs_n_o, ~ram_cs_n_o};

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Offset keeps peripheral edges off the bus clock edges
    initial begin
        peripheral_clock = 1'b0;
        #1;
        forever #6 peripheral_clock = ~peripheral_clock;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // Control byte {wr, aen, ior, memr, inta, cga_en, mda_en, hide}
    task automatic apply_vector(input int index);
        logic [7:0] ctrl;
        ctrl                      = vector_mem[index * WORDS_PER_VECTOR + 1][7:0];
        address_i                 = vector_mem[index * WORDS_PER_VECTOR][19:0];
        io_write_n_i              = ~ctrl[7];
        address_enable_n_i        = ctrl[6];
        io_read_n_i               = ~ctrl[5];
        memory_read_n_i           = ~ctrl[4];
        interrupt_acknowledge_n_i = ~ctrl[3];
        cga_enable_i              = ctrl[2];
        mda_enable_i              = ctrl[1];
        adlib_hide_i              = ctrl[0];
        internal_data_bus_i       = vector_mem[index * WORDS_PER_VECTOR + 5][7:0];
    endtask

    task automatic check_vector(input int index);
        int base;
        base = index * WORDS_PER_VECTOR;
        check($sformatf("vector %0d selects", index),
              32'(vector_mem[base + 2][10:0]), 32'(sel_actual));
        check($sformatf("vector %0d data", index),
              32'(vector_mem[base + 3][7:0]), 32'(data_bus_out_o));
        check($sformatf("vector %0d drive flag", index),
              32'(vector_mem[base + 4][0]), 32'(data_bus_out_from_chipset_o));
    endtask

    // Pulse counters, sampled away from the edges that update them
    always @(negedge clock) begin
        if (!reset) begin
            if (uart_read_o) read_pulses <= read_pulses + 1;
            if (uart_write_o) write_pulses <= write_pulses + 1;
        end
    end

    always @(negedge peripheral_clock) begin
        if (!reset && kbd_reset_request_o) begin
            kbd_reset_pulses <= kbd_reset_pulses + 1;
        end
    end

    initial begin : watchdog
        wait (vectors_loaded);
        repeat (vector_count * 10 + 400) @(posedge clock);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 vector_count * 10 + 400);
        $display("*** FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    initial begin : main
        logic   [7:0]   ctrl;
        logic           prev_read;
        logic           prev_write;
        logic   [7:0]   last_write_byte;
        int             expected_reads;
        int             expected_writes;
        int             wait_cycles;
        logic           timer_level;
        logic           expected_level;
        logic           expected_speaker;
        logic           expected_gate;

        reset                     = 1'b1;
        address_i                 = '0;
        address_enable_n_i        = 1'b0;
        io_read_n_i               = 1'b1;
        io_write_n_i              = 1'b1;
        memory_read_n_i           = 1'b1;
        internal_data_bus_i       = 8'h00;
        interrupt_acknowledge_n_i = 1'b1;
        cga_enable_i              = 1'b1;
        mda_enable_i              = 1'b1;
        adlib_hide_i              = 1'b0;
        pic_data_i                = 8'h11;
        pit_data_i                = 8'h22;
        ppi_data_i                = 8'h33;
        cga_vram_data_i           = 8'h44;
        mda_vram_data_i           = 8'h55;
        bios_data_i               = 8'h66;
        ram_data_i                = 8'h77;
        opl_data_i                = 8'h88;
        uart_readdata_i           = 8'h99;
        kbd_irq_i                 = 1'b0;
        keycode_i                 = 8'h00;
        port_b_i                  = 8'h00;
        port_b_io_i               = 1'b0;
        pit_out2_i                = 1'b0;
        prev_read                 = 1'b0;
        prev_write                = 1'b0;
        last_write_byte           = 8'h00;
        expected_reads            = 0;
        expected_writes           = 0;
        wait_cycles               = 0;

        for (int i = 0; i < MAX_WORDS; i++) vector_mem[i] = EMPTY_WORD;
        $readmemh("bench/xt_bus_testdata.hex", vector_mem);
        for (int v = 0; v < MAX_VECTORS; v++) begin
            if (vector_mem[v * WORDS_PER_VECTOR] == EMPTY_WORD) break;
            vector_count++;
        end
        if (vector_count == 0) begin
            $display("No test vectors could be read from the data file");
            $display("*** FAILED ***");
            $fatal(1, "empty vector file");
        end
        vectors_loaded = 1'b1;

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Two cycles per vector lets a UART read capture its byte
        for (int v = 0; v < vector_count; v++) begin
            ctrl = vector_mem[v * WORDS_PER_VECTOR + 1][7:0];
            if (ctrl[5] && !prev_read) expected_reads++;
            if (prev_write && !ctrl[7]) expected_writes++;
            if (ctrl[7]) last_write_byte = vector_mem[v * WORDS_PER_VECTOR + 5][7:0];
            prev_read  = ctrl[5];
            prev_write = ctrl[7];
            apply_vector(v);
            repeat (2) @(posedge clock);
            @(negedge clock);
            check_vector(v);
        end

        // Back to idle so a trailing write also ends
        if (prev_write) expected_writes++;
        io_read_n_i               = 1'b1;
        io_write_n_i              = 1'b1;
        memory_read_n_i           = 1'b1;
        interrupt_acknowledge_n_i = 1'b1;
        repeat (3) @(negedge clock);
        check("UART read pulses", expected_reads, read_pulses);
        check("UART write pulses", expected_writes, write_pulses);
        check("UART write byte", 32'(last_write_byte), 32'(uart_writedata_o));
        check("UART read capture", 32'(uart_readdata_i), 32'(uart_readdata_o));

        keycode_i = 8'hA5;
        kbd_irq_i = 1'b1;
        while (wait_cycles < 3 && !(port_a_keycode_o == 8'hA5 && keyboard_interrupt_o)) begin
            @(posedge clock);
            @(negedge clock);
            wait_cycles++;
        end
        check("keycode crossing", 32'hA5, 32'(port_a_keycode_o));
        check("keyboard irq crossing", 1, 32'(keyboard_interrupt_o));

        // One peripheral period is three bus cycles
        for (int n = 0; n < 2; n++) begin
            timer_level    = timer_clock_o;
            expected_level = ~timer_level;
            repeat (3) @(negedge clock);
            check("timer clock toggle", 32'(expected_level), 32'(timer_clock_o));
        end

        port_b_i[PB_KBD_RESET_N] = 1'b1;
        repeat (6) @(posedge peripheral_clock);
        @(negedge clock);
        check("ps2 reset release", 1, 32'(ps2_reset_n_o));
        check("keyboard reset pulses", 1, kbd_reset_pulses);
        repeat (8) @(posedge peripheral_clock);
        @(negedge clock);
        check("keyboard reset held high", 1, kbd_reset_pulses);

        // Keycode clear crosses into the peripheral domain
        check("clear keycode idle", 0, 32'(clear_keycode_o));
        port_b_i[PB_CLEAR_KEYCODE] = 1'b1;
        repeat (3) @(posedge peripheral_clock);
        @(negedge clock);
        check("clear keycode crossing", 1, 32'(clear_keycode_o));

        for (int combo = 0; combo < 16; combo++) begin
            @(negedge clock);
            pit_out2_i                = combo[0];
            port_b_i[PB_SPEAKER_DATA] = combo[1];
            port_b_io_i               = combo[2];
            port_b_i[PB_TIMER_GATE]   = combo[3];
            expected_speaker          = combo[0] & combo[1] & ~combo[2];
            expected_gate             = combo[3] & ~combo[2];
            @(posedge clock);
            check($sformatf("speaker combo %0d", combo),
                  32'(expected_speaker), 32'(speaker_o));
            check($sformatf("timer gate combo %0d", combo),
                  32'(expected_gate), 32'(timer2_gate_o));
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* bench/xt_bus_testdata.hex */
// address, ctrl {wr aen ior memr inta cga_en mda_en hide}, selects
// {dma pic pit ppi dma_page opl uart cga mda rom ram}, data, drive flag, write byte
00000 06 401 00 0 00
00020 26 201 11 1 00
00040 26 101 22 1 00
00061 26 081 33 1 00
00081 26 041 00 0 00
000A0 26 001 00 0 00
00020 66 001 00 0 00
00120 26 001 00 0 00
00388 26 021 88 1 00
00389 27 021 FF 1 00
003F8 06 011 00 0 00
003FA 26 011 99 1 00
003F8 86 011 00 0 C3
B8000 16 408 44 1 00
B8000 12 400 00 0 00
B0000 16 404 55 1 00
B0000 14 400 00 0 00
B4000 56 000 00 0 00
FFFF0 56 002 66 1 00
F0000 16 402 66 1 00
12345 16 001 77 1 00
C0000 56 001 77 1 00
12345 1E 001 11 1 00
B8000 1E 408 11 1 00
00020 36 201 11 1 00
00000 46 001 00 0 00

/* xt_bus_glue.f */
verilog/xt_bus_pkg.sv
verilog/cpu_bus_if.sv
verilog/bus_select_if.sv
verilog/xt_address_decoder.sv
verilog/read_data_mux.sv
verilog/peripheral_sync.sv
verilog/uart_bus_strobe.sv
verilog/xt_bus_glue.sv
bench/xt_bus_glue_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the XT bus glue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module xt_bus_glue_tb \
    -f xt_bus_glue.f -o xt_bus_glue_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/xt_bus_glue_sim > sim.log 2>&1
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}
